// File: run_sim.sh
#!/bin/sh
# Build and run the SSSP tile testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module sssp_tb -o sssp_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sssp_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
   exit 0
fi
exit 1

// File: src.f
sssp_pkg.sv
sssp_task_fifo.sv
sssp_task_sched.sv
sssp_relax_rw.sv
sssp_edge_fetch.sv
sssp_graph_mem.sv
sssp_tile.sv
sssp_tb_clk.sv
sssp_tb.sv

// File: sssp_edge_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module sssp_edge_fetch #(
   parameter int FETCH_DEPTH = 2,
   parameter int CHILD_DEPTH = 16
) (
   input  wire                   clk,
   input  wire                   rstn,
   input  wire                   fwd_valid,
   input  wire sssp_pkg::ts_t     fwd_ts,
   input  wire sssp_pkg::locale_t fwd_locale,
   output logic                  fetch_credit,
   input  wire sssp_pkg::addr_t   offset_base,
   input  wire sssp_pkg::addr_t   neighbor_base,
   output sssp_pkg::addr_t        mem_raddr,
   input  wire sssp_pkg::word_t   mem_rdata,
   output logic                  child_valid,
   output sssp_pkg::ts_t          child_ts,
   output sssp_pkg::locale_t      child_locale,
   input  wire                   child_credit,
   output logic                  busy
);
   import sssp_pkg::*;

   localparam int PW  = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
   localparam int BCW = $clog2(FETCH_DEPTH + 1);
   localparam int CCW = $clog2(CHILD_DEPTH + 1);

   typedef enum logic [2:0] {S_IDLE, S_OFF0, S_OFF1, S_NBR, S_WGT} fetch_state_t;

   ts_t            buf_ts  [FETCH_DEPTH];
   locale_t        buf_loc [FETCH_DEPTH];
   logic [PW-1:0]  rd_ptr;
   logic [PW-1:0]  wr_ptr;
   logic [BCW-1:0] buf_count;
   logic [CCW-1:0] ccred;
   fetch_state_t   state;
   fetch_state_t   state_next;
   ts_t            cur_ts;
   locale_t        cur_loc;
   addr_t          edge_idx;
   addr_t          edge_end;
   locale_t        nbr;
   logic           deq;
   logic           emit;
   addr_t          nbr_addr;

   // Each edge is a (neighbor, weight) word pair
   assign nbr_addr = neighbor_base + {edge_idx[14:0], 1'b0};

   always_comb begin
      state_next = state;
      mem_raddr  = offset_base + addr_t'(buf_loc[rd_ptr]);
      deq        = 1'b0;
      emit       = 1'b0;
      case (state)
         S_IDLE: begin
            if (buf_count != '0) begin
               deq        = 1'b1;
               state_next = S_OFF0;
            end
         end
         S_OFF0: begin
            mem_raddr  = offset_base + addr_t'(cur_loc) + 16'd1;
            state_next = S_OFF1;
         end
         S_OFF1: begin
            // Equal offsets mean the vertex has no outgoing edges
            mem_raddr  = nbr_addr;
            state_next = (addr_t'(mem_rdata) == edge_idx) ? S_IDLE : S_NBR;
         end
         S_NBR: begin
            mem_raddr  = nbr_addr + 16'd1;
            state_next = S_WGT;
         end
         S_WGT: begin
            // Without a child credit the weight read repeats and the edge is held
            mem_raddr = nbr_addr + 16'd1;
            if (ccred != '0) begin
               emit = 1'b1;
               if (edge_idx + 16'd1 == edge_end) begin
                  state_next = S_IDLE;
               end else begin
                  mem_raddr  = nbr_addr + 16'd2;
                  state_next = S_NBR;
               end
            end
         end
         default: state_next = S_IDLE;
      endcase
   end

   assign fetch_credit = deq;
   assign child_valid  = emit;
   assign child_ts     = cur_ts + ts_t'(mem_rdata);
   assign child_locale = nbr;
   assign busy         = (state != S_IDLE) || (buf_count != '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state     <= S_IDLE;
         rd_ptr    <= '0;
         wr_ptr    <= '0;
         buf_count <= '0;
         ccred     <= CCW'(CHILD_DEPTH);
      end else begin
         state <= state_next;
         if (fwd_valid) begin
            wr_ptr <= (wr_ptr == PW'(FETCH_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (deq) begin
            rd_ptr <= (rd_ptr == PW'(FETCH_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         buf_count <= buf_count + BCW'(fwd_valid) - BCW'(deq);
         ccred     <= ccred - CCW'(emit) + CCW'(child_credit);
      end
   end

   always_ff @(posedge clk) begin
      if (fwd_valid) begin
         buf_ts[wr_ptr]  <= fwd_ts;
         buf_loc[wr_ptr] <= fwd_locale;
      end
      if (deq) begin
         cur_ts  <= buf_ts[rd_ptr];
         cur_loc <= buf_loc[rd_ptr];
      end
      if (state == S_OFF0) begin
         edge_idx <= addr_t'(mem_rdata);
      end
      if (state == S_OFF1) begin
         edge_end <= addr_t'(mem_rdata);
      end
      if (state == S_NBR) begin
         nbr <= locale_t'(mem_rdata);
      end
      if (emit) begin
         edge_idx <= edge_idx + 16'd1;
      end
   end

endmodule

`default_nettype wire

// File: sssp_graph_mem.sv
`timescale 1ns/1ns
`default_nettype none

module sssp_graph_mem #(
   parameter int MEM_WORDS = 1024
) (
   input  wire                 clk,
   input  wire sssp_pkg::addr_t a_raddr,
   output sssp_pkg::word_t      a_rdata,
   input  wire sssp_pkg::addr_t b_raddr,
   output sssp_pkg::word_t      b_rdata,
   input  wire                 b_wvalid,
   input  wire sssp_pkg::addr_t b_waddr,
   input  wire sssp_pkg::word_t b_wdata,
   input  wire                 cfg_wvalid,
   input  wire sssp_pkg::addr_t cfg_waddr,
   input  wire sssp_pkg::word_t cfg_wdata
);
   import sssp_pkg::*;

   localparam int AW = $clog2(MEM_WORDS);

   word_t mem [MEM_WORDS];
   logic  cfg_mem_we;

   // Register writes are decoded in the tile and never reach the array
   assign cfg_mem_we = cfg_wvalid && !cfg_waddr[CFG_REG_BIT];

   always_ff @(posedge clk) begin
      if (cfg_mem_we) begin
         mem[cfg_waddr[AW-1:0]] <= cfg_wdata;
      end else if (b_wvalid) begin
         mem[b_waddr[AW-1:0]] <= b_wdata;
      end
   end

   // Both read ports return data one cycle after the address
   always_ff @(posedge clk) begin
      a_rdata <= mem[a_raddr[AW-1:0]];
      b_rdata <= mem[b_raddr[AW-1:0]];
   end

endmodule

`default_nettype wire

// File: sssp_pkg.sv
`default_nettype none

package sssp_pkg;

   // Proposed distance of a task and also the value stored in the distance array
   typedef logic [31:0] ts_t;

   // Vertex index
   typedef logic [15:0] locale_t;

   // One graph memory word
   typedef logic [31:0] word_t;

   // Word address in graph memory or in the register space
   typedef logic [15:0] addr_t;

   // Configuration writes with this address bit set go to the base registers
   localparam int CFG_REG_BIT = 15;

   // Word addresses of the base registers
   localparam addr_t REG_OFFSET_BASE   = 16'h8000;
   localparam addr_t REG_NEIGHBOR_BASE = 16'h8001;
   localparam addr_t REG_DIST_BASE     = 16'h8002;

   // Distance of a vertex that no task has reached yet
   localparam ts_t DIST_INF = '1;

endpackage

`default_nettype wire

// File: sssp_relax_rw.sv
`timescale 1ns/1ns
`default_nettype none

module sssp_relax_rw #(
   parameter int FETCH_DEPTH = 2
) (
   input  wire                   clk,
   input  wire                   rstn,
   input  wire                   task_valid,
   input  wire sssp_pkg::ts_t     task_ts,
   input  wire sssp_pkg::locale_t task_locale,
   input  wire sssp_pkg::addr_t   dist_base,
   output sssp_pkg::addr_t        mem_raddr,
   input  wire sssp_pkg::word_t   mem_rdata,
   output logic                  mem_wvalid,
   output sssp_pkg::addr_t        mem_waddr,
   output sssp_pkg::word_t        mem_wdata,
   output logic                  upd_valid,
   output sssp_pkg::locale_t      upd_locale,
   output sssp_pkg::ts_t          upd_dist,
   output logic                  fwd_valid,
   output sssp_pkg::ts_t          fwd_ts,
   output sssp_pkg::locale_t      fwd_locale,
   input  wire                   fetch_credit,
   output logic                  rw_credit,
   output logic                  fwd_pending
);
   import sssp_pkg::*;

   localparam int FCW = $clog2(FETCH_DEPTH + 1);

   logic           cmp_valid;
   logic           hold;
   ts_t            cur_ts;
   locale_t        cur_loc;
   logic [FCW-1:0] fcred;
   logic           improve;

   // Distance read is issued in the same cycle the task arrives
   assign mem_raddr = dist_base + addr_t'(task_locale);

   // Strictly smaller wins and an equal distance is not rewritten
   assign improve    = cmp_valid && (cur_ts < ts_t'(mem_rdata));
   assign mem_wvalid = improve;
   assign mem_waddr  = dist_base + addr_t'(cur_loc);
   assign mem_wdata  = word_t'(cur_ts);
   assign upd_valid  = improve;
   assign upd_locale = cur_loc;
   assign upd_dist   = cur_ts;

   assign fwd_valid   = (improve || hold) && (fcred != '0);
   assign fwd_ts      = cur_ts;
   assign fwd_locale  = cur_loc;
   assign rw_credit   = (cmp_valid && !improve) || fwd_valid;
   assign fwd_pending = cmp_valid || hold;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cmp_valid <= 1'b0;
         hold      <= 1'b0;
         fcred     <= FCW'(FETCH_DEPTH);
      end else begin
         cmp_valid <= task_valid;
         // Improved task waits here while edge fetch has no free slot
         hold      <= (improve || hold) && !fwd_valid;
         fcred     <= fcred - FCW'(fwd_valid) + FCW'(fetch_credit);
      end
   end

   always_ff @(posedge clk) begin
      if (task_valid) begin
         cur_ts  <= task_ts;
         cur_loc <= task_locale;
      end
   end

endmodule

`default_nettype wire

// File: sssp_task_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sssp_task_fifo #(
   parameter int DEPTH = 4
) (
   input  wire                   clk,
   input  wire                   rstn,
   input  wire                   push,
   input  wire sssp_pkg::ts_t     push_ts,
   input  wire sssp_pkg::locale_t push_locale,
   input  wire                   pop,
   output logic                  head_valid,
   output sssp_pkg::ts_t          head_ts,
   output sssp_pkg::locale_t      head_locale,
   output logic                  credit,
   output logic                  empty
);
   import sssp_pkg::*;

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   ts_t            ts_mem  [DEPTH];
   locale_t        loc_mem [DEPTH];
   logic [PW-1:0]  rd_ptr;
   logic [PW-1:0]  wr_ptr;
   logic [CW-1:0]  count;
   logic           do_pop;

   assign empty       = (count == '0);
   assign head_valid  = !empty;
   assign head_ts     = ts_mem[rd_ptr];
   assign head_locale = loc_mem[rd_ptr];
   assign do_pop      = pop && head_valid;

   // The producer's credits guarantee a free slot on every push
   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         credit <= do_pop;
         if (push) begin
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CW'(push) - CW'(do_pop);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         ts_mem[wr_ptr]  <= push_ts;
         loc_mem[wr_ptr] <= push_locale;
      end
   end

endmodule

`default_nettype wire

// File: sssp_task_sched.sv
`timescale 1ns/1ns
`default_nettype none

module sssp_task_sched (
   input  wire                   clk,
   input  wire                   rstn,
   input  wire                   ext_head_valid,
   input  wire sssp_pkg::ts_t     ext_head_ts,
   input  wire sssp_pkg::locale_t ext_head_locale,
   input  wire                   ext_empty,
   input  wire                   child_head_valid,
   input  wire sssp_pkg::ts_t     child_head_ts,
   input  wire sssp_pkg::locale_t child_head_locale,
   input  wire                   child_empty,
   output logic                  ext_pop,
   output logic                  child_pop,
   output logic                  rw_valid,
   output sssp_pkg::ts_t          rw_ts,
   output sssp_pkg::locale_t      rw_locale,
   input  wire                   rw_credit,
   input  wire                   fetch_busy,
   input  wire                   relax_fwd_pending,
   output logic                  idle
);

   // Relax has a single input slot, so one credit is enough
   logic rw_cred;

   // Child tasks go first so that edge fetch always drains and the chain cannot deadlock
   always_comb begin
      rw_valid  = rw_cred && (child_head_valid || ext_head_valid);
      child_pop = rw_valid && child_head_valid;
      ext_pop   = rw_valid && !child_head_valid;
      if (child_head_valid) begin
         rw_ts     = child_head_ts;
         rw_locale = child_head_locale;
      end else begin
         rw_ts     = ext_head_ts;
         rw_locale = ext_head_locale;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rw_cred <= 1'b1;
      end else begin
         case ({rw_valid, rw_credit})
            2'b10: rw_cred <= 1'b0;
            2'b01: rw_cred <= 1'b1;
            default: rw_cred <= rw_cred;
         endcase
      end
   end

   // Nothing queued, nothing in relax and nothing left in edge fetch
   assign idle = ext_empty && child_empty && rw_cred && !relax_fwd_pending && !fetch_busy;

endmodule

`default_nettype wire

// File: sssp_tb.sv
`timescale 1ns/1ns
`default_nettype none

module sssp_tb;
   import sssp_pkg::*;

   localparam int IN_DEPTH = 4;
   localparam int N_FIXED  = 3;
   localparam int N_CASES  = 7;
   localparam int MAX_V    = 12;
   localparam int MAX_E    = 24;
   localparam int FIX_NV   = 6;
   localparam int FIX_NE   = 8;
   localparam int WATCHDOG_CYCLES =
      N_CASES * (16 * MAX_V * MAX_E + 4 * (MAX_V + MAX_E) + 200) + 100;

   // Each edge is {source, destination, weight} and there is a parallel pair 0 -> 1.
   // Vertex 4 is unreachable from 0 and vertex 5 has no outgoing edges
   localparam logic [31:0] FIX_EDGES [FIX_NE] = '{
      {8'd0, 8'd1, 16'd4}, {8'd0, 8'd1, 16'd3}, {8'd0, 8'd2, 16'd1}, {8'd2, 8'd1, 16'd1},
      {8'd1, 8'd3, 16'd1}, {8'd2, 8'd3, 16'd5}, {8'd4, 8'd0, 16'd1}, {8'd3, 8'd5, 16'd2}};

   // Offset base, neighbor base, distance base and source mask of each fixed case
   localparam logic [63:0] FIX_CASES [N_FIXED] = '{
      {16'd0,   16'd16,  16'd64,  16'h0001},
      {16'd200, 16'd300, 16'd500, 16'h0001},
      {16'd40,  16'd900, 16'd8,   16'h0011}};

   logic        clk, rstn, cfg_wvalid, in_valid, in_credit, upd_valid, idle;
   addr_t       cfg_waddr;
   word_t       cfg_wdata;
   ts_t         in_ts, upd_dist;
   locale_t     in_locale, upd_locale;

   int          nv, ne, credits, injected, credit_pulses;
   logic        started, delay_inj;
   addr_t       off_base, nbr_base, dist_base;
   logic [15:0] src_mask;
   int          e_src [MAX_E];
   int          e_dst [MAX_E];
   ts_t         e_wgt [MAX_E];
   ts_t         ref_dist [MAX_V];
   ts_t         last_dist [MAX_V];

   sssp_tb_clk clk_gen (.clk(clk));

   sssp_tile #(.MEM_WORDS(1024), .IN_DEPTH(IN_DEPTH), .CHILD_DEPTH(16), .FETCH_DEPTH(2)) uut (
      .clk, .rstn, .cfg_wvalid, .cfg_waddr, .cfg_wdata, .in_valid, .in_ts, .in_locale,
      .in_credit, .upd_valid, .upd_locale, .upd_dist, .idle);

   task automatic compare(input logic [31:0] actual, input logic [31:0] exp_val,
                          input string msg);
      if (actual !== exp_val) begin
         $display("error at %0t ns: %s, got %0d, expected %0d", $time, msg, actual, exp_val);
         $display("RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // Advance to the next falling edge and look at every DUT output once
   task automatic next_cycle();
      @(negedge clk);
      if (in_credit) begin
         credits++;
         credit_pulses++;
      end
      if (!started) begin
         compare(32'(idle), 1, "idle after reset");
         compare(32'(upd_valid), 0, "update before first injection");
         compare(32'(in_credit), 0, "credit before first injection");
      end
      if (upd_valid) begin
         compare(32'(upd_locale < locale_t'(nv)), 1, "update for a vertex outside the graph");
         compare(32'(upd_dist < last_dist[upd_locale]), 1, "update does not lower the distance");
         last_dist[upd_locale] = upd_dist;
      end
   endtask

   task automatic cfg_write(input addr_t addr, input word_t data);
      cfg_wvalid = 1'b1;
      cfg_waddr  = addr;
      cfg_wdata  = data;
      next_cycle();
      cfg_wvalid = 1'b0;
   endtask

   task automatic build_case(input int c);
      int k;
      if (c < N_FIXED) begin
         nv = FIX_NV;
         ne = FIX_NE;
         for (k = 0; k < ne; k++) begin
            e_src[k] = int'(FIX_EDGES[k][31:24]);
            e_dst[k] = int'(FIX_EDGES[k][23:16]);
            e_wgt[k] = ts_t'(FIX_EDGES[k][15:0]);
         end
         {off_base, nbr_base, dist_base, src_mask} = FIX_CASES[c];
         delay_inj = 1'b0;
      end else begin
         nv = 4 + int'($urandom % 9);
         ne = int'($urandom % (MAX_E + 1));
         // The last vertex never gets an outgoing edge
         for (k = 0; k < ne; k++) begin
            e_src[k] = int'($urandom % (nv - 1));
            e_dst[k] = int'($urandom % nv);
            e_wgt[k] = ts_t'(1 + $urandom % 20);
         end
         if (ne >= 2) begin
            e_src[1] = e_src[0];
            e_dst[1] = e_dst[0];
         end
         off_base  = addr_t'(16 * ($urandom % 8));
         nbr_base  = addr_t'(128 + 64 * ($urandom % 8));
         dist_base = addr_t'(640 + $urandom % 300);
         src_mask  = '0;
         for (k = 0; k < 3; k++) begin
            src_mask[$urandom % nv] = 1'b1;
         end
         delay_inj = 1'b1;
      end
   endtask

   // Lays out the CSR arrays with edges grouped by source vertex and marks every vertex unreached
   task automatic load_graph();
      int v;
      int k;
      int idx;
      cfg_write(REG_OFFSET_BASE, word_t'(off_base));
      cfg_write(REG_NEIGHBOR_BASE, word_t'(nbr_base));
      cfg_write(REG_DIST_BASE, word_t'(dist_base));
      idx = 0;
      for (v = 0; v < nv; v++) begin
         cfg_write(off_base + addr_t'(v), word_t'(idx));
         for (k = 0; k < ne; k++) begin
            if (e_src[k] == v) begin
               cfg_write(nbr_base + addr_t'(2 * idx), word_t'(e_dst[k]));
               cfg_write(nbr_base + addr_t'(2 * idx + 1), e_wgt[k]);
               idx++;
            end
         end
         cfg_write(dist_base + addr_t'(v), DIST_INF);
         last_dist[v] = DIST_INF;
      end
      cfg_write(off_base + addr_t'(nv), word_t'(idx));
   endtask

   // Bellman-Ford over the edge list
   task automatic compute_reference();
      int v;
      int k;
      int round;
      for (v = 0; v < nv; v++) begin
         ref_dist[v] = src_mask[v] ? '0 : DIST_INF;
      end
      for (round = 0; round < nv; round++) begin
         for (k = 0; k < ne; k++) begin
            if (ref_dist[e_src[k]] != DIST_INF &&
                ref_dist[e_src[k]] + e_wgt[k] < ref_dist[e_dst[k]]) begin
               ref_dist[e_dst[k]] = ref_dist[e_src[k]] + e_wgt[k];
            end
         end
      end
   endtask

   task automatic inject_sources();
      int v;
      for (v = 0; v < nv; v++) begin
         if (src_mask[v]) begin
            if (delay_inj) begin
               repeat ($urandom % 4) next_cycle();
            end
            while (credits == 0) begin
               next_cycle();
            end
            in_valid  = 1'b1;
            in_ts     = '0;
            in_locale = locale_t'(v);
            credits--;
            injected++;
            started   = 1'b1;
            next_cycle();
            in_valid  = 1'b0;
         end
      end
   endtask

   task automatic wait_idle();
      next_cycle();
      while (!idle) begin
         next_cycle();
      end
   endtask

   initial begin
      int c;
      int v;
      void'($urandom(32'h3641_6b10));
      rstn          = 1'b0;
      cfg_wvalid    = 1'b0;
      cfg_waddr     = '0;
      cfg_wdata     = '0;
      in_valid      = 1'b0;
      in_ts         = '0;
      in_locale     = '0;
      started       = 1'b0;
      credits       = IN_DEPTH;
      injected      = 0;
      credit_pulses = 0;
      repeat (3) @(negedge clk);
      rstn = 1'b1;
      for (c = 0; c < N_CASES; c++) begin
         build_case(c);
         load_graph();
         compute_reference();
         injected      = 0;
         credit_pulses = 0;
         inject_sources();
         wait_idle();
         compare(credit_pulses, injected, "credit pulses against injections");
         compare(credits, IN_DEPTH, "credits back home at idle");
         for (v = 0; v < nv; v++) begin
            compare(last_dist[v], ref_dist[v],
                    $sformatf("case %0d distance of vertex %0d", c, v));
         end
      end
      $display("RESULT: PASS");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: the tile did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// File: sssp_tb_clk.sv
`timescale 1ns/1ns
`default_nettype none

module sssp_tb_clk (
   output logic clk
);

   // The clock toggles every 5 ns and first rises at 5 ns
   initial begin
      clk = 1'b0;
   end

   always #5 clk = ~clk;

endmodule

`default_nettype wire

// File: sssp_tile.sv
`timescale 1ns/1ns
`default_nettype none

module sssp_tile #(
   parameter int MEM_WORDS   = 1024,
   parameter int IN_DEPTH    = 4,
   parameter int CHILD_DEPTH = 16,
   parameter int FETCH_DEPTH = 2
) (
   input  wire                   clk,
   input  wire                   rstn,
   input  wire                   cfg_wvalid,
   input  wire sssp_pkg::addr_t   cfg_waddr,
   input  wire sssp_pkg::word_t   cfg_wdata,
   input  wire                   in_valid,
   input  wire sssp_pkg::ts_t     in_ts,
   input  wire sssp_pkg::locale_t in_locale,
   output logic                  in_credit,
   output logic                  upd_valid,
   output sssp_pkg::locale_t      upd_locale,
   output sssp_pkg::ts_t          upd_dist,
   output logic                  idle
);
   import sssp_pkg::*;

   addr_t   offset_base, neighbor_base, dist_base;
   logic    ext_head_valid, ext_empty, ext_pop;
   ts_t     ext_head_ts;
   locale_t ext_head_locale;
   logic    child_head_valid, child_empty, child_pop, child_credit;
   ts_t     child_head_ts;
   locale_t child_head_locale;
   logic    rw_valid, rw_credit, fwd_pending;
   ts_t     rw_ts;
   locale_t rw_locale;
   logic    fwd_valid, fetch_credit, fetch_busy;
   ts_t     fwd_ts;
   locale_t fwd_locale;
   logic    child_valid;
   ts_t     child_ts;
   locale_t child_locale;
   addr_t   a_raddr, b_raddr, b_waddr;
   word_t   a_rdata, b_rdata, b_wdata;
   logic    b_wvalid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         offset_base   <= '0;
         neighbor_base <= '0;
         dist_base     <= '0;
      end else if (cfg_wvalid && cfg_waddr[CFG_REG_BIT]) begin
         case (cfg_waddr)
            REG_OFFSET_BASE:   offset_base   <= addr_t'(cfg_wdata);
            REG_NEIGHBOR_BASE: neighbor_base <= addr_t'(cfg_wdata);
            REG_DIST_BASE:     dist_base     <= addr_t'(cfg_wdata);
            default: ;
         endcase
      end
   end

   sssp_task_fifo #(.DEPTH(IN_DEPTH)) ext_q (
      .clk, .rstn, .push(in_valid), .push_ts(in_ts), .push_locale(in_locale),
      .pop(ext_pop), .head_valid(ext_head_valid), .head_ts(ext_head_ts),
      .head_locale(ext_head_locale), .credit(in_credit), .empty(ext_empty));

   sssp_task_fifo #(.DEPTH(CHILD_DEPTH)) child_q (
      .clk, .rstn, .push(child_valid), .push_ts(child_ts), .push_locale(child_locale),
      .pop(child_pop), .head_valid(child_head_valid), .head_ts(child_head_ts),
      .head_locale(child_head_locale), .credit(child_credit), .empty(child_empty));

   sssp_task_sched sched (
      .clk, .rstn, .ext_head_valid, .ext_head_ts, .ext_head_locale, .ext_empty,
      .child_head_valid, .child_head_ts, .child_head_locale, .child_empty,
      .ext_pop, .child_pop, .rw_valid, .rw_ts, .rw_locale, .rw_credit,
      .fetch_busy, .relax_fwd_pending(fwd_pending), .idle);

   sssp_relax_rw #(.FETCH_DEPTH(FETCH_DEPTH)) relax (
      .clk, .rstn, .task_valid(rw_valid), .task_ts(rw_ts), .task_locale(rw_locale),
      .dist_base, .mem_raddr(b_raddr), .mem_rdata(b_rdata), .mem_wvalid(b_wvalid),
      .mem_waddr(b_waddr), .mem_wdata(b_wdata), .upd_valid, .upd_locale, .upd_dist,
      .fwd_valid, .fwd_ts, .fwd_locale, .fetch_credit, .rw_credit, .fwd_pending);

   sssp_edge_fetch #(.FETCH_DEPTH(FETCH_DEPTH), .CHILD_DEPTH(CHILD_DEPTH)) fetch (
      .clk, .rstn, .fwd_valid, .fwd_ts, .fwd_locale, .fetch_credit, .offset_base,
      .neighbor_base, .mem_raddr(a_raddr), .mem_rdata(a_rdata), .child_valid,
      .child_ts, .child_locale, .child_credit, .busy(fetch_busy));

   sssp_graph_mem #(.MEM_WORDS(MEM_WORDS)) gmem (
      .clk, .a_raddr, .a_rdata, .b_raddr, .b_rdata, .b_wvalid, .b_waddr, .b_wdata,
      .cfg_wvalid, .cfg_waddr, .cfg_wdata);

endmodule

`default_nettype wire
